/* pmu_testdata.txt */
# Columns: op a b, all numbers in hex
# W idx data | R idx expected | N idx data | E pattern cycles | I ovf_intr quota_intr
I 0 0
R 0 00000000
R 1 00000000
R 4 00000000
R c 00000000
R f 00000000
W 2 ffffffa5   qmask keeps only the event bits
R 2 000000a5
W 3 00000009
W 4 12345678   total is read-only
R 4 00000000
W 6 deadbeef
N 6 00000000   unselected write
R 6 deadbeef
W 0 00000001
E 05 3
E 22 2
E 81 2
I 0 1
R 4 0000000c
R 5 00000005
R 6 deadbef1
W 0 00000000   counting off
E ff 4
R 5 00000005
R 4 0000000c
W 0 00000001
W 8 ffffffff
E 08 1         counter 3 wraps
R 8 00000000
R 1 00000008
I 1 1
W 1 00000008
I 0 1
W 3 0000000c   limit equal to total
I 0 0
W 9 ffffffff
E 10 1
W 3 00000001
I 1 1
W 0 00000003   enable and soft clear
R 0 00000001
R 6 00000000
R 1 00000000
R 4 00000000
I 0 0

/* build.f */
+incdir+.
ahb_pkg.sv
pmu_pkg.sv
ahb_slave_ctrl.sv
pmu_csr_file.sv
pmu_counter_bank.sv
pmu_quota_unit.sv
pmu_ahb_top.sv
tb_pmu_ahb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the PMU AHB-lite testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f build.f --top-module tb_pmu_ahb -o sim_pmu

# The simulator exits non-zero on $fatal, the log decides the result
./obj_dir/sim_pmu > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

/* tb_pmu_ahb.sv */
/*
 * PMU AHB-lite slave testbench
 * Replays the operations of the test data file on the AHB port and the
 * event lines, and checks read data, responses and both interrupts
 */

`timescale 1ns/1ns
`default_nettype none

`include "pmu_cfg.svh"

module tb_pmu_ahb import ahb_pkg::*, pmu_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int DRIVE_DLY  = 1;
    localparam int RST_CYCLES = 3;
    // Spare cycles on top of the budget from the data file
    localparam int MARGIN     = 20;

    logic                   clk;
    logic                   rstn;
    logic                   hsel;
    logic                   hreadyi;
    logic [`PMU_DATA_W-1:0] haddr;
    logic                   hwrite;
    htrans_e                htrans;
    pmu_word_t              hwdata;
    ev_vec_t                events;
    logic                   hreadyo;
    hresp_e                 hresp;
    pmu_word_t              hrdata;
    logic                   intr_ovf;
    logic                   intr_quota;

    // Operations from the data file
    byte         op_q[$];
    pmu_word_t   a_q[$];
    pmu_word_t   b_q[$];
    int unsigned budget;
    logic        loaded;
    int          n_checks;
    logic [31:0] lfsr;

    pmu_ahb_top dut0 (
        .clk_i(clk), .rstn_i(rstn), .hsel_i(hsel), .hreadyi_i(hreadyi), .haddr_i(haddr),
        .hwrite_i(hwrite), .htrans_i(htrans), .hwdata_i(hwdata), .hreadyo_o(hreadyo),
        .hresp_o(hresp), .hrdata_o(hrdata), .events_i(events),
        .intr_overflow_o(intr_ovf), .intr_quota_o(intr_quota)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_word(input string name, input pmu_word_t got, input pmu_word_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic check_resp(input string name, input hresp_e got, input hresp_e exp);
        n_checks++;
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %s expected %s", $time, name, got.name(),
                     exp.name());
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One random bit decides on one idle cycle
    task automatic idle_gap();
        logic take;
        take = lfsr[0];
        lfsr = lfsr_step(lfsr);
        if (take) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    // Address phase, then data phase with the bus idle; starts and ends 1 ns after an edge
    task automatic ahb_transfer(input logic sel, input logic write, input pmu_idx_t idx,
                                input pmu_word_t wdata, input logic rd_check,
                                input pmu_word_t exp_rdata);
        hsel   = sel;
        htrans = NONSEQ;
        hwrite = write;
        haddr  = pmu_word_t'(idx) << 2;
        @(posedge clk);
        #DRIVE_DLY;
        hsel   = 1'b0;
        htrans = IDLE;
        hwrite = 1'b0;
        hwdata = write ? wdata : '0;
        // Mid data phase, everything settled
        @(negedge clk);
        check_bit("hreadyo_o", hreadyo, 1'b1);
        check_resp("hresp_o", hresp, OKAY);
        if (rd_check) begin
            check_word("hrdata_o", hrdata, exp_rdata);
        end
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // Reads all operations and sums their worst-case cycles
    task automatic load_ops();
        int        fd;
        string     line;
        byte       op;
        pmu_word_t a;
        pmu_word_t b;
        fd = $fopen("pmu_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file pmu_testdata.txt");
            $display("FAIL: see errors above");
            $fatal(1);
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#" &&
                    $sscanf(line, "%c %h %h", op, a, b) == 3) begin
                    op_q.push_back(op);
                    a_q.push_back(a);
                    b_q.push_back(b);
                    // Transfer is two cycles plus an optional idle one
                    budget += (op == "E") ? b : ((op == "I") ? 1 : 3);
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------
    // Watchdog
    // ------------------------------
    initial begin
        wait (loaded === 1'b1);
        #((budget + RST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("Timeout: the tests did not finish within their cycle budget");
        $display("FAIL: see errors above");
        $fatal(1);
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        rstn     = 1'b0;
        hsel     = 1'b0;
        hreadyi  = 1'b1;
        haddr    = '0;
        hwrite   = 1'b0;
        htrans   = IDLE;
        hwdata   = '0;
        events   = '0;
        lfsr     = 32'hf15c;
        budget   = 0;
        n_checks = 0;
        loaded   = 1'b0;
        load_ops();
        loaded = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rstn = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "W": ahb_transfer(1'b1, 1'b1, a_q[i][`PMU_IDX_W-1:0], b_q[i], 1'b0, '0);
                "N": ahb_transfer(1'b0, 1'b1, a_q[i][`PMU_IDX_W-1:0], b_q[i], 1'b0, '0);
                "R": ahb_transfer(1'b1, 1'b0, a_q[i][`PMU_IDX_W-1:0], '0, 1'b1, b_q[i]);
                "E": begin
                    // Pattern seen by exactly b rising edges
                    events = a_q[i][`PMU_N_COUNTERS-1:0];
                    repeat (b_q[i]) @(posedge clk);
                    #DRIVE_DLY;
                    events = '0;
                end
                "I": begin
                    @(negedge clk);
                    check_bit("intr_overflow_o", intr_ovf, a_q[i][0]);
                    check_bit("intr_quota_o", intr_quota, b_q[i][0]);
                    @(posedge clk);
                    #DRIVE_DLY;
                end
                default: begin
                    $display("Unknown operation %c in the test data file", op_q[i]);
                    $display("FAIL: see errors above");
                    $fatal(1);
                end
            endcase
            if (op_q[i] == "W" || op_q[i] == "N" || op_q[i] == "R") begin
                idle_gap();
            end
        end
        if (n_checks > 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("No checks ran, the test data file held no operations");
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* pmu_ahb_top.sv */
/*
 * PMU AHB-lite slave, top level
 * AHB control, register file, event counters and quota unit
 */

`timescale 1ns/1ns
`default_nettype none

`include "pmu_cfg.svh"

module pmu_ahb_top import ahb_pkg::*, pmu_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    // AHB-lite slave port
    input  logic                   hsel_i,
    input  logic                   hreadyi_i,
    input  logic [`PMU_DATA_W-1:0] haddr_i,
    input  logic                   hwrite_i,
    input  htrans_e                htrans_i,
    input  pmu_word_t              hwdata_i,
    output logic                   hreadyo_o,
    output hresp_e                 hresp_o,
    output pmu_word_t              hrdata_o,
    // SoC events and interrupts
    input  ev_vec_t                events_i,
    output logic                   intr_overflow_o,
    output logic                   intr_quota_o
);

    // ------------------------------
    // Internal nets
    // ------------------------------
    logic                            wr_en;
    pmu_idx_t                        acc_idx;
    logic                            enable;
    logic                            clear;
    ev_vec_t                         qmask;
    pmu_word_t                       qlimit;
    pmu_word_t [`PMU_N_COUNTERS-1:0] cnt_val;
    ev_vec_t                         wrap;
    pmu_word_t                       qacc;

    ahb_slave_ctrl u_ctrl (.clk_i, .rstn_i, .hsel_i, .hreadyi_i, .htrans_i, .hwrite_i,
        .haddr_i, .wr_en_o(wr_en), .acc_idx_o(acc_idx), .hreadyo_o, .hresp_o);

    pmu_csr_file u_csr (.clk_i, .rstn_i, .wr_en_i(wr_en), .acc_idx_i(acc_idx), .hwdata_i,
        .cnt_val_i(cnt_val), .wrap_i(wrap), .qacc_i(qacc), .enable_o(enable),
        .clear_o(clear), .qmask_o(qmask), .qlimit_o(qlimit), .hrdata_o, .intr_overflow_o);

    pmu_counter_bank u_cnt (.clk_i, .rstn_i, .events_i, .enable_i(enable), .clear_i(clear),
        .wr_en_i(wr_en), .acc_idx_i(acc_idx), .hwdata_i, .cnt_val_o(cnt_val), .wrap_o(wrap));

    pmu_quota_unit u_quota (.clk_i, .rstn_i, .events_i, .enable_i(enable), .clear_i(clear),
        .qmask_i(qmask), .qlimit_i(qlimit), .qacc_o(qacc), .intr_quota_o);

endmodule

`default_nettype wire

/* pmu_quota_unit.sv */
/*
 * PMU quota unit
 * Adds the number of masked events each enabled cycle into a
 * saturating total and flags when the total exceeds the limit.
 */

`timescale 1ns/1ns
`default_nettype none

`include "pmu_cfg.svh"

module pmu_quota_unit import pmu_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  ev_vec_t   events_i,
    input  logic      enable_i,
    input  logic      clear_i,
    input  ev_vec_t   qmask_i,
    input  pmu_word_t qlimit_i,
    output pmu_word_t qacc_o,
    output logic      intr_quota_o
);

    // Enough bits to count every event line at once
    localparam int POP_W = $clog2(`PMU_N_COUNTERS) + 1;

    ev_vec_t                masked;
    logic [POP_W-1:0]       pop;
    logic [`PMU_DATA_W:0]   sum;
    pmu_word_t              qacc_q;

    // Popcount of masked events, plus carry-out for saturation
    always_comb begin
        masked = events_i & qmask_i;
        pop    = '0;
        for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
            pop = pop + POP_W'(masked[i]);
        end
        sum = {1'b0, qacc_q} + (`PMU_DATA_W+1)'(pop);
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            qacc_q <= '0;
        end else if (clear_i) begin
            qacc_q <= '0;
        end else if (enable_i) begin
            // Stick at all ones instead of wrapping
            qacc_q <= sum[`PMU_DATA_W] ? '1 : sum[`PMU_DATA_W-1:0];
        end
    end

    assign qacc_o       = qacc_q;
    assign intr_quota_o = (qacc_q > qlimit_i);

endmodule

`default_nettype wire

/* pmu_counter_bank.sv */
/*
 * PMU event counters
 * One 32-bit counter per event line. Software can load any counter
 * through its register index. Flags a wrap from all ones to zero.
 */

`timescale 1ns/1ns
`default_nettype none

`include "pmu_cfg.svh"

module pmu_counter_bank import pmu_pkg::*; (
    input  logic                             clk_i,
    input  logic                             rstn_i,
    input  ev_vec_t                          events_i,
    input  logic                             enable_i,
    input  logic                             clear_i,
    input  logic                             wr_en_i,
    input  pmu_idx_t                         acc_idx_i,
    input  pmu_word_t                        hwdata_i,
    output pmu_word_t [`PMU_N_COUNTERS-1:0]  cnt_val_o,
    output ev_vec_t                          wrap_o
);

    // ------------------------------
    // Counter slices
    // ------------------------------
    for (genvar k = 0; k < `PMU_N_COUNTERS; k++) begin : g_cnt
        // Register index of this counter
        localparam pmu_idx_t CNT_IDX = pmu_idx_t'(int'(REG_CNT0) + k);

        pmu_word_t cnt_q;
        logic      wr_hit;
        logic      inc;

        assign wr_hit = wr_en_i && (acc_idx_i == CNT_IDX);
        assign inc    = enable_i && events_i[k];

        // Priority is soft clear, then software load, then increment
        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                cnt_q <= '0;
            end else if (clear_i) begin
                cnt_q <= '0;
            end else if (wr_hit) begin
                cnt_q <= hwdata_i;
            end else if (inc) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end

        // Wrap only when the increment really happens this edge
        assign wrap_o[k] = inc && !wr_hit && !clear_i && (&cnt_q);

        assign cnt_val_o[k] = cnt_q;
    end

endmodule

`default_nettype wire

/* pmu_csr_file.sv */
/*
 * PMU control and status registers
 * Control, sticky overflow, quota mask and quota limit registers,
 * plus the read multiplexer onto hrdata_o.
 */

`timescale 1ns/1ns
`default_nettype none

`include "pmu_cfg.svh"

module pmu_csr_file import pmu_pkg::*; (
    input  logic                             clk_i,
    input  logic                             rstn_i,
    input  logic                             wr_en_i,
    input  pmu_idx_t                         acc_idx_i,
    input  pmu_word_t                        hwdata_i,
    input  pmu_word_t [`PMU_N_COUNTERS-1:0]  cnt_val_i,
    input  ev_vec_t                          wrap_i,
    input  pmu_word_t                        qacc_i,
    output logic                             enable_o,
    output logic                             clear_o,
    output ev_vec_t                          qmask_o,
    output pmu_word_t                        qlimit_o,
    output pmu_word_t                        hrdata_o,
    output logic                             intr_overflow_o
);

    localparam int CNT_SEL_W = $clog2(`PMU_N_COUNTERS);

    logic      ctrl_en_q;
    logic      clear_q;
    ev_vec_t   ovf_q;
    ev_vec_t   ovf_d;
    ev_vec_t   ovf_w1c;
    ev_vec_t   qmask_q;
    pmu_word_t qlimit_q;
    pmu_idx_t  cnt_off;
    logic      wr_ctrl;
    logic      wr_ovf;
    logic      wr_qmask;
    logic      wr_qlimit;

    // Write decode, QACC and counters are handled elsewhere
    assign wr_ctrl   = wr_en_i && (acc_idx_i == REG_CTRL);
    assign wr_ovf    = wr_en_i && (acc_idx_i == REG_OVF);
    assign wr_qmask  = wr_en_i && (acc_idx_i == REG_QMASK);
    assign wr_qlimit = wr_en_i && (acc_idx_i == REG_QLIMIT);

    // ------------------------------
    // Sticky overflow bits
    // ------------------------------
    // Soft clear wins, then a new wrap wins over the W1C
    assign ovf_w1c = wr_ovf ? hwdata_i[`PMU_N_COUNTERS-1:0] : '0;
    assign ovf_d   = clear_q ? '0 : ((ovf_q & ~ovf_w1c) | wrap_i);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ctrl_en_q <= 1'b0;
            clear_q   <= 1'b0;
            ovf_q     <= '0;
            qmask_q   <= '0;
            qlimit_q  <= '0;
        end else begin
            if (wr_ctrl) begin
                ctrl_en_q <= hwdata_i[CTRL_EN_BIT];
            end
            // Self-clearing request, a clear already in flight covers a repeat
            clear_q <= wr_ctrl && hwdata_i[CTRL_CLR_BIT] && !clear_q;
            if (wr_qmask) begin
                qmask_q <= hwdata_i[`PMU_N_COUNTERS-1:0];
            end
            if (wr_qlimit) begin
                qlimit_q <= hwdata_i;
            end
            ovf_q <= ovf_d;
        end
    end

    // ------------------------------
    // Read multiplexer
    // ------------------------------
    assign cnt_off = acc_idx_i - REG_CNT0;

    always_comb begin
        hrdata_o = '0;
        case (acc_idx_i)
            REG_CTRL:   hrdata_o[CTRL_EN_BIT] = ctrl_en_q;
            REG_OVF:    hrdata_o[`PMU_N_COUNTERS-1:0] = ovf_q;
            REG_QMASK:  hrdata_o[`PMU_N_COUNTERS-1:0] = qmask_q;
            REG_QLIMIT: hrdata_o = qlimit_q;
            REG_QACC:   hrdata_o = qacc_i;
            default: begin
                // Counter window, anything past it reads zero
                if (acc_idx_i >= REG_CNT0 && acc_idx_i < `PMU_N_REGS) begin
                    hrdata_o = cnt_val_i[cnt_off[CNT_SEL_W-1:0]];
                end
            end
        endcase
    end

    assign enable_o        = ctrl_en_q;
    assign clear_o         = clear_q;
    assign qmask_o         = qmask_q;
    assign qlimit_o        = qlimit_q;
    assign intr_overflow_o = |ovf_q;

    // Soft clear is a single-cycle pulse
    a_clear_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        clear_o |=> !clear_o);

endmodule

`default_nettype wire

/* ahb_slave_ctrl.sv */
/*
 * AHB-lite slave control
 * Samples the address phase, keeps the data-phase state and the word index,
 * and raises the register write strobe during a write data phase.
 * Zero wait states, always OKAY.
 */

`timescale 1ns/1ns
`default_nettype none

`include "pmu_cfg.svh"

module ahb_slave_ctrl import ahb_pkg::*, pmu_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    // AHB address phase
    input  logic                   hsel_i,
    input  logic                   hreadyi_i,
    input  htrans_e                htrans_i,
    input  logic                   hwrite_i,
    input  logic [`PMU_DATA_W-1:0] haddr_i,
    // Register side
    output logic                   wr_en_o,
    output pmu_idx_t               acc_idx_o,
    // AHB response
    output logic                   hreadyo_o,
    output hresp_e                 hresp_o
);

    ahb_phase_e phase_q;
    ahb_phase_e phase_d;
    pmu_idx_t   idx_q;

    // ------------------------------
    // Address phase decode
    // ------------------------------
    // Previous transfer must be done (hreadyi_i) before a new one is taken
    always_comb begin
        phase_d = PH_IDLE;
        if (hsel_i && hreadyi_i) begin
            case (htrans_i)
                NONSEQ, SEQ: phase_d = hwrite_i ? PH_WRITE : PH_READ;
                IDLE, BUSY:  phase_d = PH_IDLE;
                default:     phase_d = PH_IDLE;
            endcase
        end
    end

    // ------------------------------
    // Data phase state
    // ------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            phase_q <= PH_IDLE;
            idx_q   <= '0;
        end else begin
            phase_q <= phase_d;
            // Index held between transfers, so idle reads show the last register
            if (phase_d != PH_IDLE) begin
                idx_q <= haddr_i[`PMU_IDX_W+1:2];
            end
        end
    end

    // Write commits at the edge that ends the data phase
    assign wr_en_o   = (phase_q == PH_WRITE);
    assign acc_idx_o = idx_q;

    // No wait states, no error responses
    assign hreadyo_o = 1'b1;
    assign hresp_o   = OKAY;

    // ------------------------------
    // Checks
    // ------------------------------
    // Unselected cycle never produces a write strobe
    a_no_wr_unsel: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !hsel_i |=> !wr_en_o);

    // Every accepted write address phase yields a write strobe next cycle
    a_wr_follows: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (hsel_i && hreadyi_i && hwrite_i && (htrans_i == NONSEQ || htrans_i == SEQ))
        |=> wr_en_o);

    // Response stays OKAY through reset release and beyond
    a_resp_okay: assert property (@(posedge clk_i) hresp_o != ERROR);

endmodule

`default_nettype wire

/* pmu_pkg.sv */
/*
 * PMU types
 * Register words, word index, register map and the AHB data-phase states
 */

`default_nettype none

`include "pmu_cfg.svh"

package pmu_pkg;

    // Register word and word index
    typedef logic [`PMU_DATA_W-1:0] pmu_word_t;
    typedef logic [`PMU_IDX_W-1:0]  pmu_idx_t;

    // One bit per event line
    typedef logic [`PMU_N_COUNTERS-1:0] ev_vec_t;

    // Register map, counter k lives at REG_CNT0 + k
    typedef enum logic [`PMU_IDX_W-1:0] {
        REG_CTRL   = 4'd0,
        REG_OVF    = 4'd1,
        REG_QMASK  = 4'd2,
        REG_QLIMIT = 4'd3,
        REG_QACC   = 4'd4,
        REG_CNT0   = 4'd5
    } pmu_reg_e;

    // Control register fields
    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_CLR_BIT = 1;

    // What the slave does in the current data phase
    typedef enum logic [1:0] {PH_IDLE, PH_READ, PH_WRITE} ahb_phase_e;

endpackage

`default_nettype wire

/* ahb_pkg.sv */
/*
 * AHB-lite types
 * Transfer type and response encodings seen by the slave
 */

`default_nettype none

package ahb_pkg;

    // ------------------------------
    // HTRANS encodings
    // ------------------------------
    // Only NONSEQ and SEQ carry a transfer
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // ------------------------------
    // HRESP encodings
    // ------------------------------
    // Slave never stalls and never errors
    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_e;

endpackage

`default_nettype wire

/* pmu_cfg.svh */
/*
 * PMU configuration
 * Sizes shared by the AHB register slave and the PMU datapath
 */

`ifndef PMU_CFG_SVH
`define PMU_CFG_SVH

// ------------------------------
// Bus and register sizes
// ------------------------------

// Register and AHB data width
`define PMU_DATA_W 32

// Event lines, one counter each
`define PMU_N_COUNTERS 8

// Word index taken from haddr bits 5..2
`define PMU_IDX_W 4

// Control, overflow, mask, limit, total and eight counters
`define PMU_N_REGS 13

`endif
